//--- common/axi_mc_settings.svh
`ifndef AXI_MC_SETTINGS_SVH
`define AXI_MC_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI command path widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// AXI byte address.
`define AXI_MC_ADDR_WIDTH 32

// AXI beats per controller command.
`define AXI_MC_BURST_LEN 2

// Log2 of bytes per beat.
`define AXI_MC_AXSIZE 2

`endif

//--- common/axi_mc_pkg.sv
`default_nettype none

`include "axi_mc_settings.svh"

package axi_mc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic {
    IDLE  = 1'b0,  // Waiting for a request.
    ISSUE = 1'b1   // Handing out commands.
  } cmd_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request and command bundles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [`AXI_MC_ADDR_WIDTH-1:0] addr;
    logic [7:0]                    len;   // Beats minus one.
    logic [2:0]                    size;
    axi_burst_e                    burst;
  } ax_req_t;

  typedef struct packed {
    logic [`AXI_MC_ADDR_WIDTH-1:0] byte_addr;
    logic                          ignore_begin;  // Lower beat unused.
    logic                          ignore_end;    // Upper beat unused.
  } mc_cmd_t;

endpackage

`default_nettype wire

//--- cmd_translate/axi_mc_wrap_cmd.sv
`timescale 1ns/1ns
`default_nettype none

`include "axi_mc_settings.svh"

module axi_mc_wrap_cmd (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic [`AXI_MC_ADDR_WIDTH-1:0] axaddr_i,
  input  wire logic [7:0]                    axlen_i,
  input  wire logic                          axhandshake_i,
  input  wire logic                          next_i,
  output axi_mc_pkg::mc_cmd_t                cmd_o,
  output logic                               next_pending_o
);

  localparam int         IDX_LSB  = `AXI_MC_AXSIZE;
  localparam int         IDX_MSB  = `AXI_MC_AXSIZE + 3;
  localparam logic [3:0] IDX_STEP = 4'(`AXI_MC_BURST_LEN);

  logic [`AXI_MC_ADDR_WIDTH-1:0] base_q;
  logic [3:0]                    mask_q;
  logic [3:0]                    idx_q;
  logic [3:0]                    idx_inc;
  logic [3:0]                    idx_nxt;
  logic [3:0]                    cnt_q;
  logic                          cnt_pending;
  logic                          odd_q;
  logic                          first_q;
  logic                          pend_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Word index stepping
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign idx_inc = idx_q + IDX_STEP;

  // Bits under the mask roll over, the rest stay put.
  assign idx_nxt = (idx_q & ~mask_q) | (idx_inc & mask_q);

  always_ff @(posedge clk) begin
    if (axhandshake_i) begin
      base_q <= axaddr_i;
      mask_q <= axlen_i[3:0];           // Wrap window in beats.
      idx_q  <= axaddr_i[IDX_MSB:IDX_LSB];
    end else if (next_i) begin
      idx_q <= idx_nxt;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command count
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign cnt_pending = |cnt_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q   <= 4'd0;
      odd_q   <= 1'b0;
      first_q <= 1'b0;
      pend_q  <= 1'b0;
    end else if (axhandshake_i) begin
      cnt_q   <= {1'b0, axlen_i[3:1]};  // Commands minus one.
      odd_q   <= axaddr_i[IDX_LSB];     // Odd start adds a command.
      first_q <= 1'b1;
      pend_q  <= 1'b1;
    end else if (next_i) begin
      if (cnt_pending) begin
        cnt_q <= cnt_q - 4'd1;
      end
      first_q <= 1'b0;
      pend_q  <= cnt_pending;           // Lags the count by one command.
    end
  end

  assign next_pending_o = odd_q ? pend_q : cnt_pending;

  always_comb begin
    cmd_o.byte_addr    = {base_q[`AXI_MC_ADDR_WIDTH-1:IDX_MSB+1], idx_q,
                          base_q[IDX_LSB-1:0]};
    cmd_o.ignore_begin = first_q & odd_q;
    cmd_o.ignore_end   = odd_q & ~next_pending_o;
  end

  // Only power-of-two windows of 2 to 16 beats wrap.
  a_wrap_len: assert property (
    @(posedge clk) disable iff (reset)
      axhandshake_i |-> (axlen_i inside {8'd1, 8'd3, 8'd7, 8'd15})
  ) else $error("wrap burst with unsupported len %0d", axlen_i);

endmodule

`default_nettype wire

//--- cmd_translate/axi_mc_incr_cmd.sv
`timescale 1ns/1ns
`default_nettype none

`include "axi_mc_settings.svh"

module axi_mc_incr_cmd (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic [`AXI_MC_ADDR_WIDTH-1:0] axaddr_i,
  input  wire logic [7:0]                    axlen_i,
  input  wire logic                          axhandshake_i,
  input  wire logic                          next_i,
  output axi_mc_pkg::mc_cmd_t                cmd_o,
  output logic                               next_pending_o
);

  localparam int CMD_BYTES = `AXI_MC_BURST_LEN << `AXI_MC_AXSIZE;
  localparam int CMD_LSB   = $clog2(CMD_BYTES);
  localparam logic [`AXI_MC_ADDR_WIDTH-1:0] CMD_STEP = CMD_BYTES;

  logic [`AXI_MC_ADDR_WIDTH-1:0] addr_q;
  logic [`AXI_MC_ADDR_WIDTH-1:0] addr_aligned;
  logic [8:0]                    beat_sum;
  logic [7:0]                    cnt_q;
  logic                          begin_q;
  logic                          end_q;

  // Beat offset plus len, nine bits so len 255 fits.
  assign beat_sum = {1'b0, axlen_i} + 9'(axaddr_i[`AXI_MC_AXSIZE]);

  assign addr_aligned = {addr_q[`AXI_MC_ADDR_WIDTH-1:CMD_LSB], {CMD_LSB{1'b0}}};

  always_ff @(posedge clk) begin
    if (axhandshake_i) begin
      addr_q <= axaddr_i;               // First command goes out as is.
      end_q  <= ~beat_sum[0];
    end else if (next_i) begin
      addr_q <= addr_aligned + CMD_STEP;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q   <= 8'd0;
      begin_q <= 1'b0;
    end else if (axhandshake_i) begin
      cnt_q   <= beat_sum[8:1];         // Commands minus one.
      begin_q <= axaddr_i[`AXI_MC_AXSIZE];
    end else if (next_i) begin
      if (next_pending_o) begin
        cnt_q <= cnt_q - 8'd1;
      end
      begin_q <= 1'b0;
    end
  end

  assign next_pending_o = |cnt_q;

  always_comb begin
    cmd_o.byte_addr    = addr_q;
    cmd_o.ignore_begin = begin_q;
    cmd_o.ignore_end   = end_q & ~next_pending_o;
  end

endmodule

`default_nettype wire

//--- cmd_translate/axi_mc_cmd_translator.sv
`timescale 1ns/1ns
`default_nettype none

`include "axi_mc_settings.svh"

module axi_mc_cmd_translator (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire axi_mc_pkg::ax_req_t  ax_req_i,
  input  wire logic                 axhandshake_i,
  input  wire logic                 next_i,
  output axi_mc_pkg::mc_cmd_t       cmd_o,
  output logic                      next_pending_o
);

  axi_mc_pkg::axi_burst_e burst_q;
  axi_mc_pkg::mc_cmd_t    incr_cmd;
  axi_mc_pkg::mc_cmd_t    wrap_cmd;
  logic                   incr_pending;
  logic                   wrap_pending;
  logic                   incr_hs;
  logic                   wrap_hs;
  logic                   wrap_sel;

  always_ff @(posedge clk) begin
    if (reset) begin
      burst_q <= axi_mc_pkg::INCR;
    end else if (axhandshake_i) begin
      burst_q <= ax_req_i.burst;
    end
  end

  // Only the generator that owns the burst loads.
  assign incr_hs  = axhandshake_i & (ax_req_i.burst == axi_mc_pkg::INCR);
  assign wrap_hs  = axhandshake_i & (ax_req_i.burst == axi_mc_pkg::WRAP);
  assign wrap_sel = (burst_q == axi_mc_pkg::WRAP);

  axi_mc_incr_cmd axi_mc_incr_cmd_inst (
    .clk            (clk),
    .reset          (reset),
    .axaddr_i       (ax_req_i.addr),
    .axlen_i        (ax_req_i.len),
    .axhandshake_i  (incr_hs),
    .next_i         (next_i & ~wrap_sel),
    .cmd_o          (incr_cmd),
    .next_pending_o (incr_pending)
  );

  axi_mc_wrap_cmd axi_mc_wrap_cmd_inst (
    .clk            (clk),
    .reset          (reset),
    .axaddr_i       (ax_req_i.addr),
    .axlen_i        (ax_req_i.len),
    .axhandshake_i  (wrap_hs),
    .next_i         (next_i & wrap_sel),
    .cmd_o          (wrap_cmd),
    .next_pending_o (wrap_pending)
  );

  assign cmd_o          = wrap_sel ? wrap_cmd : incr_cmd;
  assign next_pending_o = wrap_sel ? wrap_pending : incr_pending;

  a_no_fixed: assert property (
    @(posedge clk) disable iff (reset)
      axhandshake_i |-> (ax_req_i.burst != axi_mc_pkg::FIXED)
  ) else $error("FIXED burst accepted");

  a_size: assert property (
    @(posedge clk) disable iff (reset)
      axhandshake_i |-> (ax_req_i.size == 3'(`AXI_MC_AXSIZE))
  ) else $error("unsupported axsize %0d", ax_req_i.size);

endmodule

`default_nettype wire

//--- src/axi_mc_cmd_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module axi_mc_cmd_fsm (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic axvalid_i,
  output logic      axready_o,
  input  wire logic mc_full_i,
  input  wire logic next_pending_i,
  output logic      cmd_en_o,
  output logic      axhandshake_o,
  output logic      next_o
);

  axi_mc_pkg::cmd_state_e state_q;
  axi_mc_pkg::cmd_state_e state_d;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Strobes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign axready_o     = (state_q == axi_mc_pkg::IDLE);
  assign cmd_en_o      = (state_q == axi_mc_pkg::ISSUE);
  assign axhandshake_o = axvalid_i & axready_o;
  assign next_o        = cmd_en_o & ~mc_full_i;  // Controller took it.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State transitions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_d = state_q;
    case (state_q)
      axi_mc_pkg::IDLE: begin
        if (axhandshake_o) begin
          state_d = axi_mc_pkg::ISSUE;
        end
      end
      axi_mc_pkg::ISSUE: begin
        // Last command leaves on a next with nothing behind it.
        if (next_o && !next_pending_i) begin
          state_d = axi_mc_pkg::IDLE;
        end
      end
      default: begin
        state_d = axi_mc_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= axi_mc_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Back-pressure keeps the current command on offer.
  a_hold_while_full: assert property (
    @(posedge clk) disable iff (reset)
      (cmd_en_o && mc_full_i) |=> cmd_en_o
  ) else $error("command dropped while controller full");

endmodule

`default_nettype wire

//--- src/axi_mc_cmd_path.sv
`timescale 1ns/1ns
`default_nettype none

`include "axi_mc_settings.svh"

module axi_mc_cmd_path #(
  parameter int ADDR_WIDTH = `AXI_MC_ADDR_WIDTH
) (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire axi_mc_pkg::ax_req_t ax_req_i,
  input  wire logic                axvalid_i,
  output logic                     axready_o,
  output axi_mc_pkg::mc_cmd_t      mc_cmd_o,
  output logic                     cmd_en_o,
  input  wire logic                mc_full_i
);

  logic axhandshake;
  logic next;
  logic next_pending;

  // Package address width must agree with the instance.
  if (ADDR_WIDTH != $bits(ax_req_i.addr)) begin : g_addr_width_check
    $error("ADDR_WIDTH %0d differs from request address width", ADDR_WIDTH);
  end

  axi_mc_cmd_fsm axi_mc_cmd_fsm_inst (
    .clk            (clk),
    .reset          (reset),
    .axvalid_i      (axvalid_i),
    .axready_o      (axready_o),
    .mc_full_i      (mc_full_i),
    .next_pending_i (next_pending),
    .cmd_en_o       (cmd_en_o),
    .axhandshake_o  (axhandshake),
    .next_o         (next)
  );

  axi_mc_cmd_translator axi_mc_cmd_translator_inst (
    .clk            (clk),
    .reset          (reset),
    .ax_req_i       (ax_req_i),
    .axhandshake_i  (axhandshake),
    .next_i         (next),
    .cmd_o          (mc_cmd_o),
    .next_pending_o (next_pending)
  );

endmodule

`default_nettype wire

//--- testbench/tb_axi_mc_cmd_path.sv
`timescale 1ns/1ns
`default_nettype none

`include "axi_mc_settings.svh"

module tb_axi_mc_cmd_path;

  localparam int CMD_BYTES      = `AXI_MC_BURST_LEN << `AXI_MC_AXSIZE;
  localparam int TIMEOUT_CYCLES = 3000;  // Tests need about 250 cycles.

  logic                clk = 1'b0;
  logic                reset;
  axi_mc_pkg::ax_req_t ax_req;
  logic                axvalid;
  logic                axready;
  axi_mc_pkg::mc_cmd_t mc_cmd;
  logic                cmd_en;
  logic                mc_full;

  axi_mc_pkg::mc_cmd_t exp_q[$];          // Expected commands of one burst.
  logic [15:0]         lfsr_q = 16'd26864;
  int                  cycle_count = 0;

  axi_mc_cmd_path axi_mc_cmd_path_inst (
    .clk       (clk),
    .reset     (reset),
    .ax_req_i  (ax_req),
    .axvalid_i (axvalid),
    .axready_o (axready),
    .mc_cmd_o  (mc_cmd),
    .cmd_en_o  (cmd_en),
    .mc_full_i (mc_full)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Verification failed");
      $fatal(1, "Timeout, tests still running after %0d cycles", TIMEOUT_CYCLES);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] shifted;
    shifted = s >> 1;
    if (s[0]) begin
      shifted = shifted ^ 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1.
    end
    return shifted;
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] expected,
                       input string what);
    if (got !== expected) begin
      $display("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, got, expected);
      $display("Verification failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic build_incr_model(input logic [31:0] addr, input logic [7:0] len);
    logic [8:0]          sum;
    logic [31:0]         base;
    int                  n;
    axi_mc_pkg::mc_cmd_t c;
    exp_q.delete();
    sum  = 9'(len) + 9'(addr[`AXI_MC_AXSIZE]);
    n    = int'(sum >> 1) + 1;
    base = addr & ~32'(CMD_BYTES - 1);
    for (int i = 0; i < n; i++) begin
      c.byte_addr    = (i == 0) ? addr : base + 32'(CMD_BYTES * i);
      c.ignore_begin = (i == 0) && addr[`AXI_MC_AXSIZE];
      c.ignore_end   = (i == n - 1) && !sum[0];  // Even sum leaves top beat empty.
      exp_q.push_back(c);
    end
  endtask

  task automatic build_wrap_model(input logic [31:0] addr, input logic [7:0] len);
    logic [3:0]          idx0;
    logic [3:0]          mask;
    logic [3:0]          idx;
    logic                odd;
    int                  n;
    axi_mc_pkg::mc_cmd_t c;
    exp_q.delete();
    idx0 = addr[5:2];
    mask = len[3:0];
    odd  = addr[2];
    n    = int'(len >> 1) + 1 + int'(odd);
    for (int i = 0; i < n; i++) begin
      idx            = (idx0 & ~mask) | ((idx0 + 4'(2 * i)) & mask);
      c.byte_addr    = {addr[`AXI_MC_ADDR_WIDTH-1:6], idx, addr[1:0]};
      c.ignore_begin = odd && (i == 0);
      c.ignore_end   = odd && (i == n - 1);
      exp_q.push_back(c);
    end
  endtask

  // One request, then every command compared as it is offered.
  task automatic run_burst(input logic [31:0] addr, input logic [7:0] len,
                           input axi_mc_pkg::axi_burst_e burst, input logic stall);
    string ctx;
    int    k;
    logic  full;
    ctx = $sformatf("%s addr 0x%08h len %0d", burst.name(), addr, len);
    if (burst == axi_mc_pkg::WRAP) begin
      build_wrap_model(addr, len);
    end else begin
      build_incr_model(addr, len);
    end
    check(64'(axready), 64'(1'b1), {ctx, ": axready before request"});
    check(64'(cmd_en), 64'(1'b0), {ctx, ": cmd_en before request"});
    ax_req.addr  = addr;
    ax_req.len   = len;
    ax_req.size  = 3'(`AXI_MC_AXSIZE);
    ax_req.burst = burst;
    axvalid      = 1'b1;
    mc_full      = 1'b0;
    @(negedge clk);
    axvalid     = 1'b0;
    ax_req.addr = ~addr;  // Fields must not matter once accepted.
    ax_req.len  = ~len;
    check(64'(cmd_en), 64'(1'b1), {ctx, ": cmd_en one cycle after handshake"});
    k = 0;
    while (k < exp_q.size()) begin
      check(64'(cmd_en), 64'(1'b1), $sformatf("%s cmd %0d: cmd_en", ctx, k));
      check(64'(axready), 64'(1'b0), $sformatf("%s cmd %0d: axready", ctx, k));
      check(64'(mc_cmd), 64'(exp_q[k]), $sformatf("%s cmd %0d: command", ctx, k));
      full = 1'b0;
      if (stall) begin
        full   = lfsr_q[0];
        lfsr_q = lfsr_step(lfsr_q);
      end
      mc_full = full;
      @(negedge clk);
      if (!full) begin
        k++;
      end
    end
    mc_full = 1'b0;
    check(64'(axready), 64'(1'b1), {ctx, ": axready after last command"});
    check(64'(cmd_en), 64'(1'b0), {ctx, ": cmd_en after last command"});
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset_state();
    check(64'(axready), 64'(1'b1), "axready after reset");
    check(64'(cmd_en), 64'(1'b0), "cmd_en after reset");
  endtask

  task automatic test_incr_aligned();
    run_burst(32'h1000_0000, 8'd0, axi_mc_pkg::INCR, 1'b0);
    run_burst(32'h1000_0040, 8'd1, axi_mc_pkg::INCR, 1'b0);
    run_burst(32'h2000_0108, 8'd6, axi_mc_pkg::INCR, 1'b0);
    run_burst(32'h3000_0200, 8'd31, axi_mc_pkg::INCR, 1'b0);
  endtask

  task automatic test_incr_unaligned();
    run_burst(32'h1000_0004, 8'd0, axi_mc_pkg::INCR, 1'b0);
    run_burst(32'h1000_000C, 8'd1, axi_mc_pkg::INCR, 1'b0);
    run_burst(32'h2000_0014, 8'd6, axi_mc_pkg::INCR, 1'b0);
    run_burst(32'h3000_0104, 8'd31, axi_mc_pkg::INCR, 1'b0);
  endtask

  task automatic test_wrap_aligned();
    for (int l = 1; l <= 3; l++) begin
      for (int s = 0; s < 3; s++) begin
        run_burst(32'h4000_1A40 + 32'(s * 24), 8'((1 << (l + 1)) - 1),
                  axi_mc_pkg::WRAP, 1'b0);  // Word index 0, 6, 12.
      end
    end
  endtask

  task automatic test_wrap_odd();
    for (int l = 0; l <= 3; l++) begin
      for (int s = 0; s < 3; s++) begin
        run_burst(32'h5000_2C84 + 32'(s * 24), 8'((1 << (l + 1)) - 1),
                  axi_mc_pkg::WRAP, 1'b0);  // Word index 1, 7, 13.
      end
    end
  endtask

  task automatic test_backpressure();
    run_burst(32'h2000_0108, 8'd6, axi_mc_pkg::INCR, 1'b1);
    run_burst(32'h3000_0104, 8'd31, axi_mc_pkg::INCR, 1'b1);
    run_burst(32'h5000_2C9C, 8'd15, axi_mc_pkg::WRAP, 1'b1);
    run_burst(32'h4000_1A58, 8'd7, axi_mc_pkg::WRAP, 1'b1);
  endtask

  initial begin
    reset   = 1'b1;
    axvalid = 1'b0;
    ax_req  = '0;
    mc_full = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    test_reset_state();
    test_incr_aligned();
    test_incr_unaligned();
    test_wrap_aligned();
    test_wrap_odd();
    test_backpressure();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- axi_mc_cmd.f
+incdir+common
common/axi_mc_pkg.sv
cmd_translate/axi_mc_wrap_cmd.sv
cmd_translate/axi_mc_incr_cmd.sv
cmd_translate/axi_mc_cmd_translator.sv
src/axi_mc_cmd_fsm.sv
src/axi_mc_cmd_path.sv
testbench/tb_axi_mc_cmd_path.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the AXI command path testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
    -f axi_mc_cmd.f \
    --top-module tb_axi_mc_cmd_path \
    --Mdir obj_dir \
    -o sim_axi_mc_cmd; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_axi_mc_cmd
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit "$status"
fi

exit 0
